// ==== hdl/curve_pkg.sv ====
package curve_pkg;

  // Scalar and coordinate width
  localparam int KEY_BITS = 256;

  // One beat of the command and reply streams
  localparam int WORD_BITS = 64;

  localparam int WORDS_PER_KEY = KEY_BITS / WORD_BITS;

  // secp256k1 group order
  localparam logic [KEY_BITS-1:0] CURVE_N =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;

endpackage

// ==== hdl/cmd_pkg.sv ====
package cmd_pkg;

  import curve_pkg::*;

  // Command codes
  localparam logic [15:0] CMD_VERIFY_SIG = 16'h0100;
  localparam logic [15:0] CMD_VERIFY_RPL = 16'h0101;

  // Header view of a command word, code in the top bits
  typedef struct packed {
    logic [15:0] cmd;
    logic [15:0] len;
    logic [31:0] rsvd;
  } cmd_hdr_t;

  typedef union packed {
    cmd_hdr_t             hdr;
    logic [WORD_BITS-1:0] raw;
  } cmd_word_u;

  // Parameter RAM
  localparam int RAM_DEPTH     = 32;
  localparam int RAM_ADDR_BITS = 5;

  // Register map, multi-word values least significant word first
  localparam logic [RAM_ADDR_BITS-1:0] REG_CMD   = 5'd0;
  localparam logic [RAM_ADDR_BITS-1:0] REG_INDEX = 5'd1;
  localparam logic [RAM_ADDR_BITS-1:0] REG_S     = 5'd2;
  localparam logic [RAM_ADDR_BITS-1:0] REG_R     = 5'd6;
  localparam logic [RAM_ADDR_BITS-1:0] REG_HASH  = 5'd10;
  localparam logic [RAM_ADDR_BITS-1:0] REG_Q     = 5'd14;
  localparam logic [RAM_ADDR_BITS-1:0] REG_W     = 5'd22;

  // Index, then s, r, hash, Q.x and Q.y
  localparam int PAYLOAD_BEATS = 21;

  // Reply status byte
  localparam int STAT_BITS    = 8;
  localparam int STAT_S_RANGE = 0;
  localparam int STAT_R_RANGE = 1;

endpackage

// ==== hdl/param_ram.sv ====
`timescale 1ns/10ps

module param_ram import curve_pkg::*, cmd_pkg::*; (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_we,
  input  logic [RAM_ADDR_BITS-1:0] i_waddr,
  input  logic [WORD_BITS-1:0]     i_wdat,
  input  logic                     i_dbg_rd,
  input  logic [RAM_ADDR_BITS-1:0] i_dbg_addr,
  output logic [WORD_BITS-1:0]     o_dbg_dat,
  output logic                     o_dbg_val
);

logic [WORD_BITS-1:0] mem [0:RAM_DEPTH-1];
logic [WORD_BITS-1:0] rd_q;
logic                 rd_d1;

// Two register stages on the read side
always_ff @(posedge i_clk) begin
  if (i_we)
    mem[i_waddr] <= i_wdat;
  if (i_dbg_rd)
    rd_q <= mem[i_dbg_addr];
  if (rd_d1)
    o_dbg_dat <= rd_q;
end

always_ff @(posedge i_clk) begin
  if (i_rst) begin
    rd_d1     <= 1'b0;
    o_dbg_val <= 1'b0;
  end else begin
    rd_d1     <= i_dbg_rd;
    o_dbg_val <= rd_d1;
  end
end

endmodule

// ==== hdl/mod_inverse.sv ====
`timescale 1ns/10ps

module mod_inverse import curve_pkg::*; (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_val,
  input  logic [KEY_BITS-1:0] i_dat,
  output logic                o_rdy,
  output logic                o_val,
  output logic [KEY_BITS-1:0] o_dat,
  input  logic                i_rdy
);

typedef enum logic [1:0] {
  INV_IDLE,
  INV_RUN,
  INV_DONE
} inv_state_t;

inv_state_t          state;
// Invariant: x1*a = u and x2*a = v, modulo n
logic [KEY_BITS-1:0] u;
logic [KEY_BITS-1:0] v;
logic [KEY_BITS-1:0] x1;
logic [KEY_BITS-1:0] x2;

// x/2 mod n, n is odd so an odd x gets n added first
function automatic logic [KEY_BITS-1:0] half_mod(input logic [KEY_BITS-1:0] x);
  logic [KEY_BITS:0] t;
  t = x[0] ? ({1'b0, x} + {1'b0, CURVE_N}) : {1'b0, x};
  return t[KEY_BITS:1];
endfunction

function automatic logic [KEY_BITS-1:0] sub_mod(input logic [KEY_BITS-1:0] a,
                                                input logic [KEY_BITS-1:0] b);
  logic [KEY_BITS-1:0] d;
  d = a - b;
  if (a < b)
    d = d + CURVE_N;
  return d;
endfunction

assign o_rdy = (state == INV_IDLE);
assign o_val = (state == INV_DONE);
assign o_dat = (u == KEY_BITS'(1)) ? x1 : x2;

always_ff @(posedge i_clk) begin
  if (i_rst) begin
    state <= INV_IDLE;
  end else begin
    case (state)
      INV_IDLE: begin
        if (i_val) begin
          u     <= i_dat;
          v     <= CURVE_N;
          x1    <= KEY_BITS'(1);
          x2    <= '0;
          state <= INV_RUN;
        end
      end
      INV_RUN: begin
        // Every step at least halves u*v, so 512 steps at most
        if (u == KEY_BITS'(1) || v == KEY_BITS'(1)) begin
          state <= INV_DONE;
        end else if (!u[0]) begin
          u  <= u >> 1;
          x1 <= half_mod(x1);
        end else if (!v[0]) begin
          v  <= v >> 1;
          x2 <= half_mod(x2);
        end else if (u >= v) begin
          // Both odd, so the difference is even and halves right away
          u  <= (u - v) >> 1;
          x1 <= half_mod(sub_mod(x1, x2));
        end else begin
          v  <= (v - u) >> 1;
          x2 <= half_mod(sub_mod(x2, x1));
        end
      end
      INV_DONE: begin
        if (i_rdy)
          state <= INV_IDLE;
      end
      default: state <= INV_IDLE;
    endcase
  end
end

// Zero has no inverse and would never terminate
a_nonzero_start: assert property (@(posedge i_clk) disable iff (i_rst)
  (i_val && o_rdy) |-> (i_dat != '0));

endmodule

// ==== hdl/reply_tx.sv ====
`timescale 1ns/10ps

module reply_tx import curve_pkg::*, cmd_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_start,
  input  logic [STAT_BITS-1:0] i_status,
  input  logic [WORD_BITS-1:0] i_index,
  output logic                 o_busy,
  output cmd_word_u            o_rpl_dat,
  output logic                 o_rpl_val,
  output logic                 o_rpl_sop,
  output logic                 o_rpl_eop,
  input  logic                 i_rpl_rdy
);

cmd_word_u hdr_word;
cmd_word_u stat_word;
cmd_word_u stat_q;

always_comb begin
  hdr_word.hdr.cmd  = CMD_VERIFY_RPL;
  hdr_word.hdr.len  = 16'd1;
  hdr_word.hdr.rsvd = '0;
  // Status on top, low part of the index below
  stat_word.raw = {i_status, i_index[WORD_BITS-STAT_BITS-1:0]};
end

assign o_busy = o_rpl_val;

always_ff @(posedge i_clk) begin
  if (i_rst) begin
    o_rpl_val <= 1'b0;
    o_rpl_sop <= 1'b0;
    o_rpl_eop <= 1'b0;
  end else if (!o_rpl_val) begin
    if (i_start) begin
      o_rpl_val <= 1'b1;
      o_rpl_sop <= 1'b1;
      o_rpl_eop <= 1'b0;
      o_rpl_dat <= hdr_word;
      stat_q    <= stat_word;
    end
  end else if (i_rpl_rdy) begin
    if (o_rpl_sop) begin
      o_rpl_sop <= 1'b0;
      o_rpl_eop <= 1'b1;
      o_rpl_dat <= stat_q;
    end else begin
      o_rpl_val <= 1'b0;
      o_rpl_eop <= 1'b0;
    end
  end
end

a_hold_stable: assert property (@(posedge i_clk) disable iff (i_rst)
  (o_rpl_val && !i_rpl_rdy) |=>
  (o_rpl_val && $stable(o_rpl_dat) && $stable(o_rpl_sop) && $stable(o_rpl_eop)));

endmodule

// ==== hdl/sig_ctrl.sv ====
`timescale 1ns/10ps

module sig_ctrl import curve_pkg::*, cmd_pkg::*; (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  cmd_word_u                i_cmd_dat,
  input  logic                     i_cmd_val,
  input  logic                     i_cmd_sop,
  input  logic                     i_cmd_eop,
  output logic                     o_cmd_rdy,
  output logic                     o_ram_we,
  output logic [RAM_ADDR_BITS-1:0] o_ram_addr,
  output logic [WORD_BITS-1:0]     o_ram_dat,
  output logic                     o_inv_val,
  output logic [KEY_BITS-1:0]      o_inv_dat,
  input  logic                     i_inv_rdy,
  input  logic                     i_inv_res_val,
  input  logic [KEY_BITS-1:0]      i_inv_res,
  output logic                     o_inv_res_rdy,
  output logic                     o_rpl_start,
  output logic [STAT_BITS-1:0]     o_rpl_status,
  output logic [WORD_BITS-1:0]     o_rpl_index,
  input  logic                     i_rpl_busy
);

typedef enum logic [2:0] {
  ST_IDLE,
  ST_INDEX,
  ST_PAYLOAD,
  ST_RANGE,
  ST_INV_WAIT,
  ST_W_WRITE,
  ST_REPLY,
  ST_SKIP
} state_t;

state_t                             state;
logic [$clog2(PAYLOAD_BEATS)-1:0]   cnt;
logic [KEY_BITS-1:0]                s_key;
logic [KEY_BITS-1:0]                r_key;
logic [KEY_BITS-1:0]                w_key;
logic                               rpl_sent;
logic                               cmd_fire;
logic                               s_bad;
logic                               r_bad;

assign cmd_fire  = i_cmd_val && o_cmd_rdy;
assign s_bad     = (s_key == '0) || (s_key >= CURVE_N);
assign r_bad     = (r_key == '0) || (r_key >= CURVE_N);
assign o_inv_dat = s_key;

always_ff @(posedge i_clk) begin
  if (i_rst) begin
    state         <= ST_IDLE;
    cnt           <= '0;
    o_cmd_rdy     <= 1'b0;
    o_ram_we      <= 1'b0;
    o_inv_val     <= 1'b0;
    o_inv_res_rdy <= 1'b0;
    o_rpl_start   <= 1'b0;
    rpl_sent      <= 1'b0;
  end else begin
    o_ram_we    <= 1'b0;
    o_rpl_start <= 1'b0;
    if (o_inv_val && i_inv_rdy)
      o_inv_val <= 1'b0;

    case (state)
      ST_IDLE: begin
        o_cmd_rdy <= 1'b1;
        cnt       <= '0;
        rpl_sent  <= 1'b0;
        // Beats without sop are dropped here
        if (cmd_fire && i_cmd_sop) begin
          if (i_cmd_dat.hdr.cmd == CMD_VERIFY_SIG) begin
            o_ram_we   <= 1'b1;
            o_ram_addr <= REG_CMD;
            o_ram_dat  <= i_cmd_dat.raw;
            state      <= ST_INDEX;
          end else if (!i_cmd_eop) begin
            state <= ST_SKIP;
          end
        end
      end
      ST_INDEX: begin
        if (cmd_fire) begin
          o_ram_we    <= 1'b1;
          o_ram_addr  <= REG_INDEX;
          o_ram_dat   <= i_cmd_dat.raw;
          o_rpl_index <= i_cmd_dat.raw;
          state       <= ST_PAYLOAD;
        end
      end
      ST_PAYLOAD: begin
        if (cmd_fire) begin
          // s, r, hash and Q sit back to back from REG_S
          o_ram_we   <= 1'b1;
          o_ram_addr <= REG_S + RAM_ADDR_BITS'(cnt);
          o_ram_dat  <= i_cmd_dat.raw;
          if (cnt < WORDS_PER_KEY)
            s_key[cnt[1:0]*WORD_BITS +: WORD_BITS] <= i_cmd_dat.raw;
          else if (cnt < 2*WORDS_PER_KEY)
            r_key[cnt[1:0]*WORD_BITS +: WORD_BITS] <= i_cmd_dat.raw;
          cnt <= cnt + 1'b1;
          if (cnt == ($bits(cnt))'(PAYLOAD_BEATS - 2)) begin
            o_cmd_rdy <= 1'b0;
            state     <= ST_RANGE;
          end
        end
      end
      ST_RANGE: begin
        cnt                        <= '0;
        o_rpl_status               <= '0;
        o_rpl_status[STAT_S_RANGE] <= s_bad;
        o_rpl_status[STAT_R_RANGE] <= r_bad;
        if (s_bad) begin
          // No inverse exists, store zero for w
          w_key <= '0;
          state <= ST_W_WRITE;
        end else begin
          o_inv_val     <= 1'b1;
          o_inv_res_rdy <= 1'b1;
          state         <= ST_INV_WAIT;
        end
      end
      ST_INV_WAIT: begin
        if (i_inv_res_val && o_inv_res_rdy) begin
          w_key         <= i_inv_res;
          o_inv_res_rdy <= 1'b0;
          state         <= ST_W_WRITE;
        end
      end
      ST_W_WRITE: begin
        o_ram_we   <= 1'b1;
        o_ram_addr <= REG_W + RAM_ADDR_BITS'(cnt);
        o_ram_dat  <= w_key[cnt[1:0]*WORD_BITS +: WORD_BITS];
        cnt        <= cnt + 1'b1;
        if (cnt == ($bits(cnt))'(WORDS_PER_KEY - 1))
          state <= ST_REPLY;
      end
      ST_REPLY: begin
        // Stay here until the reply has fully left, holding off the next command
        if (!rpl_sent) begin
          if (!i_rpl_busy) begin
            o_rpl_start <= 1'b1;
            rpl_sent    <= 1'b1;
          end
        end else if (!o_rpl_start && !i_rpl_busy) begin
          state <= ST_IDLE;
        end
      end
      ST_SKIP: begin
        if (cmd_fire && i_cmd_eop)
          state <= ST_IDLE;
      end
      default: state <= ST_IDLE;
    endcase
  end
end

// New packets only begin while the FSM is idle
a_hdr_in_idle: assert property (@(posedge i_clk) disable iff (i_rst)
  (i_cmd_val && o_cmd_rdy && i_cmd_sop) |-> (state == ST_IDLE));

endmodule

// ==== hdl/sig_precheck_top.sv ====
`timescale 1ns/10ps

module sig_precheck_top import curve_pkg::*, cmd_pkg::*; (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  cmd_word_u                i_cmd_dat,
  input  logic                     i_cmd_val,
  input  logic                     i_cmd_sop,
  input  logic                     i_cmd_eop,
  output logic                     o_cmd_rdy,
  output cmd_word_u                o_rpl_dat,
  output logic                     o_rpl_val,
  output logic                     o_rpl_sop,
  output logic                     o_rpl_eop,
  input  logic                     i_rpl_rdy,
  input  logic                     i_dbg_rd,
  input  logic [RAM_ADDR_BITS-1:0] i_dbg_addr,
  output logic [WORD_BITS-1:0]     o_dbg_dat,
  output logic                     o_dbg_val
);

logic                     ram_we;
logic [RAM_ADDR_BITS-1:0] ram_addr;
logic [WORD_BITS-1:0]     ram_dat;
logic                     inv_val;
logic [KEY_BITS-1:0]      inv_dat;
logic                     inv_rdy;
logic                     inv_res_val;
logic [KEY_BITS-1:0]      inv_res;
logic                     inv_res_rdy;
logic                     rpl_start;
logic [STAT_BITS-1:0]     rpl_status;
logic [WORD_BITS-1:0]     rpl_index;
logic                     rpl_busy;

sig_ctrl u_sig_ctrl (
  .i_clk         ( i_clk       ),
  .i_rst         ( i_rst       ),
  .i_cmd_dat     ( i_cmd_dat   ),
  .i_cmd_val     ( i_cmd_val   ),
  .i_cmd_sop     ( i_cmd_sop   ),
  .i_cmd_eop     ( i_cmd_eop   ),
  .o_cmd_rdy     ( o_cmd_rdy   ),
  .o_ram_we      ( ram_we      ),
  .o_ram_addr    ( ram_addr    ),
  .o_ram_dat     ( ram_dat     ),
  .o_inv_val     ( inv_val     ),
  .o_inv_dat     ( inv_dat     ),
  .i_inv_rdy     ( inv_rdy     ),
  .i_inv_res_val ( inv_res_val ),
  .i_inv_res     ( inv_res     ),
  .o_inv_res_rdy ( inv_res_rdy ),
  .o_rpl_start   ( rpl_start   ),
  .o_rpl_status  ( rpl_status  ),
  .o_rpl_index   ( rpl_index   ),
  .i_rpl_busy    ( rpl_busy    )
);

// Inverse of s modulo the group order
mod_inverse u_mod_inverse (
  .i_clk ( i_clk       ),
  .i_rst ( i_rst       ),
  .i_val ( inv_val     ),
  .i_dat ( inv_dat     ),
  .o_rdy ( inv_rdy     ),
  .o_val ( inv_res_val ),
  .o_dat ( inv_res     ),
  .i_rdy ( inv_res_rdy )
);

reply_tx u_reply_tx (
  .i_clk     ( i_clk      ),
  .i_rst     ( i_rst      ),
  .i_start   ( rpl_start  ),
  .i_status  ( rpl_status ),
  .i_index   ( rpl_index  ),
  .o_busy    ( rpl_busy   ),
  .o_rpl_dat ( o_rpl_dat  ),
  .o_rpl_val ( o_rpl_val  ),
  .o_rpl_sop ( o_rpl_sop  ),
  .o_rpl_eop ( o_rpl_eop  ),
  .i_rpl_rdy ( i_rpl_rdy  )
);

param_ram u_param_ram (
  .i_clk      ( i_clk      ),
  .i_rst      ( i_rst      ),
  .i_we       ( ram_we     ),
  .i_waddr    ( ram_addr   ),
  .i_wdat     ( ram_dat    ),
  .i_dbg_rd   ( i_dbg_rd   ),
  .i_dbg_addr ( i_dbg_addr ),
  .o_dbg_dat  ( o_dbg_dat  ),
  .o_dbg_val  ( o_dbg_val  )
);

endmodule

// ==== testbench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic abort_run();
  $display("Done: errors found");
  $fatal(1);
endtask

task automatic check_word(input string name, input cmd_word_u got, input cmd_word_u exp);
  if (got !== exp) begin
    $display("FAIL %s: got %h expected %h", name, got.raw, exp.raw);
    abort_run();
  end
endtask

task automatic check_key(input string name, input logic [KEY_BITS-1:0] got,
                         input logic [KEY_BITS-1:0] exp);
  if (got !== exp) begin
    $display("FAIL %s: got %h expected %h", name, got, exp);
    abort_run();
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("FAIL %s: got %h expected %h", name, got, exp);
    abort_run();
  end
endtask

// Full 512-bit product, then reduced modulo the group order
function automatic logic [KEY_BITS-1:0] mul_mod(input logic [KEY_BITS-1:0] a,
                                                input logic [KEY_BITS-1:0] b);
  logic [2*KEY_BITS-1:0] p;
  p = {{KEY_BITS{1'b0}}, a} * {{KEY_BITS{1'b0}}, b};
  p = p % {{KEY_BITS{1'b0}}, CURVE_N};
  return p[KEY_BITS-1:0];
endfunction

`endif

// ==== testbench/tb_sig_precheck.sv ====
`timescale 1ns/10ps

module tb_sig_precheck import curve_pkg::*, cmd_pkg::*; ();

localparam int CYCLE_LIMIT = 6 * 700;

logic                     i_clk;
logic                     i_rst;
cmd_word_u                i_cmd_dat;
logic                     i_cmd_val;
logic                     i_cmd_sop;
logic                     i_cmd_eop;
logic                     o_cmd_rdy;
cmd_word_u                o_rpl_dat;
logic                     o_rpl_val;
logic                     o_rpl_sop;
logic                     o_rpl_eop;
logic                     i_rpl_rdy;
logic                     i_dbg_rd;
logic [RAM_ADDR_BITS-1:0] i_dbg_addr;
logic [WORD_BITS-1:0]     o_dbg_dat;
logic                     o_dbg_val;

integer               seed = 32'h683aebce;
int                   cycles = 0;
// Beat k of the last command lands at RAM address k
cmd_word_u            sent [0:PAYLOAD_BEATS];
logic [WORD_BITS-1:0] rd_words [0:2*WORDS_PER_KEY-1];

`include "tb_checks.svh"

sig_precheck_top DUT (.*);

initial begin
  i_clk = 1'b0;
  forever #20 i_clk = ~i_clk;
end

always @(posedge i_clk) begin
  cycles <= cycles + 1;
  if (cycles >= CYCLE_LIMIT) begin
    $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
    abort_run();
  end
end

// Random scalar in 1..n-1
function automatic logic [KEY_BITS-1:0] rand_key();
  logic [KEY_BITS-1:0] k;
  for (int i = 0; i < KEY_BITS / 32; i++)
    k[i*32 +: 32] = $random(seed);
  if (k >= CURVE_N)
    k = k - CURVE_N;
  if (k == '0)
    k = KEY_BITS'(1);
  return k;
endfunction

task automatic send_command(input logic [15:0] code, input logic [WORD_BITS-1:0] index,
                            input logic [KEY_BITS-1:0] s, input logic [KEY_BITS-1:0] r,
                            input int n_beats);
  bit taken;
  sent[0].hdr.cmd  = code;
  sent[0].hdr.len  = 16'(n_beats - 1);
  sent[0].hdr.rsvd = '0;
  sent[1].raw      = index;
  for (int i = 2; i <= PAYLOAD_BEATS; i++)
    sent[i].raw = {$random(seed), $random(seed)};
  for (int i = 0; i < WORDS_PER_KEY; i++) begin
    sent[REG_S + i].raw = s[i*WORD_BITS +: WORD_BITS];
    sent[REG_R + i].raw = r[i*WORD_BITS +: WORD_BITS];
  end
  for (int i = 0; i < n_beats; i++) begin
    i_cmd_dat = sent[i];
    i_cmd_sop = (i == 0);
    i_cmd_eop = (i == n_beats - 1);
    i_cmd_val = 1'b1;
    taken     = 1'b0;
    while (!taken) begin
      @(negedge i_clk);
      taken = o_cmd_rdy;
      @(posedge i_clk);
      #2;
    end
  end
  i_cmd_val = 1'b0;
  i_cmd_sop = 1'b0;
  i_cmd_eop = 1'b0;
endtask

task automatic collect_reply(input logic [STAT_BITS-1:0] status,
                             input logic [WORD_BITS-1:0] index, input bit rnd);
  cmd_word_u   exp [0:1];
  cmd_word_u   held;
  logic        held_sop;
  logic        held_eop;
  logic        stall;
  logic [31:0] r;
  int          got;
  exp[0].hdr.cmd  = CMD_VERIFY_RPL;
  exp[0].hdr.len  = 16'd1;
  exp[0].hdr.rsvd = '0;
  exp[1].raw      = {status, index[WORD_BITS-STAT_BITS-1:0]};
  got   = 0;
  stall = 1'b0;
  while (got < 2) begin
    r         = $random(seed);
    i_rpl_rdy = rnd ? r[0] : 1'b1;
    @(negedge i_clk);
    // A beat that was refused must still be there, unchanged
    if (stall) begin
      check_bit("o_rpl_val held", o_rpl_val, 1'b1);
      check_word("o_rpl_dat held", o_rpl_dat, held);
      check_bit("o_rpl_sop held", o_rpl_sop, held_sop);
      check_bit("o_rpl_eop held", o_rpl_eop, held_eop);
    end
    stall    = o_rpl_val && !i_rpl_rdy;
    held     = o_rpl_dat;
    held_sop = o_rpl_sop;
    held_eop = o_rpl_eop;
    if (o_rpl_val && i_rpl_rdy) begin
      check_word("o_rpl_dat", o_rpl_dat, exp[got]);
      check_bit("o_rpl_sop", o_rpl_sop, got == 0);
      check_bit("o_rpl_eop", o_rpl_eop, got == 1);
      got++;
    end
    @(posedge i_clk);
    #2;
  end
  i_rpl_rdy = 1'b0;
endtask

// Back-to-back reads with each word due two cycles after its strobe
task automatic dbg_read(input logic [RAM_ADDR_BITS-1:0] base, input int n);
  for (int c = 0; c < n + 2; c++) begin
    i_dbg_rd   = (c < n);
    i_dbg_addr = base + RAM_ADDR_BITS'(c);
    @(negedge i_clk);
    check_bit("o_dbg_val", o_dbg_val, c >= 2);
    if (c >= 2)
      rd_words[c-2] = o_dbg_dat;
    @(posedge i_clk);
    #2;
  end
  i_dbg_rd = 1'b0;
endtask

task automatic run_verify(input logic [KEY_BITS-1:0] s, input logic [KEY_BITS-1:0] r,
                          input logic [STAT_BITS-1:0] status, input bit rnd);
  logic [WORD_BITS-1:0] index;
  logic [KEY_BITS-1:0]  w;
  index = {$random(seed), $random(seed)};
  send_command(CMD_VERIFY_SIG, index, s, r, PAYLOAD_BEATS + 1);
  collect_reply(status, index, rnd);
  dbg_read(REG_W, WORDS_PER_KEY);
  for (int i = 0; i < WORDS_PER_KEY; i++)
    w[i*WORD_BITS +: WORD_BITS] = rd_words[i];
  if (status[STAT_S_RANGE])
    check_key("REG_W", w, '0);
  else
    check_key("s*w mod n", mul_mod(s, w), KEY_BITS'(1));
endtask

task automatic check_stored_words();
  dbg_read(REG_INDEX, 1);
  check_word("REG_INDEX", cmd_word_u'(rd_words[0]), sent[REG_INDEX]);
  dbg_read(REG_HASH, WORDS_PER_KEY);
  for (int i = 0; i < WORDS_PER_KEY; i++)
    check_word("REG_HASH", cmd_word_u'(rd_words[i]), sent[REG_HASH + i]);
  dbg_read(REG_Q, 2 * WORDS_PER_KEY);
  for (int i = 0; i < 2 * WORDS_PER_KEY; i++)
    check_word("REG_Q", cmd_word_u'(rd_words[i]), sent[REG_Q + i]);
endtask

task automatic expect_no_reply(input int n_cycles);
  i_rpl_rdy = 1'b1;
  repeat (n_cycles) begin
    @(negedge i_clk);
    check_bit("o_rpl_val", o_rpl_val, 1'b0);
  end
  @(posedge i_clk);
  #2;
  i_rpl_rdy = 1'b0;
endtask

initial begin
  i_rst      = 1'b1;
  i_cmd_dat  = '0;
  i_cmd_val  = 1'b0;
  i_cmd_sop  = 1'b0;
  i_cmd_eop  = 1'b0;
  i_rpl_rdy  = 1'b0;
  i_dbg_rd   = 1'b0;
  i_dbg_addr = '0;
  repeat (16) @(posedge i_clk);
  #2;
  i_rst = 1'b0;
  check_bit("o_cmd_rdy", o_cmd_rdy, 1'b0);
  check_bit("o_rpl_val", o_rpl_val, 1'b0);
  check_bit("o_dbg_val", o_dbg_val, 1'b0);

  // Valid s and r, then the stored words of that command
  run_verify(rand_key(), rand_key(), '0, 1'b0);
  check_stored_words();
  // s equal to n
  run_verify(CURVE_N, rand_key(), STAT_BITS'(1 << STAT_S_RANGE), 1'b0);
  // r zero with a usable s
  run_verify(rand_key(), '0, STAT_BITS'(1 << STAT_R_RANGE), 1'b0);
  // Unknown command is dropped and the next verify is answered
  send_command(16'h0200, {$random(seed), $random(seed)}, rand_key(), rand_key(), 6);
  expect_no_reply(30);
  run_verify(rand_key(), rand_key(), '0, 1'b0);
  // Reply under random back-pressure
  run_verify(rand_key(), rand_key(), '0, 1'b1);

  $display("Done: no errors");
  $finish;
end

endmodule

// ==== all.f ====
+incdir+testbench
hdl/curve_pkg.sv
hdl/cmd_pkg.sv
hdl/param_ram.sv
hdl/mod_inverse.sv
hdl/reply_tx.sv
hdl/sig_ctrl.sv
hdl/sig_precheck_top.sv
testbench/tb_sig_precheck.sv

// ==== Makefile ====
TOP = tb_sig_precheck

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
